// File: src/ringbuf_pkg.sv
package ringbuf_pkg;

	// Sample ring
	localparam int RING_DEPTH = 4096;
	localparam int RING_AW    = $clog2(RING_DEPTH);
	localparam int SAMP_W     = 12;

	// Trigger record queue, 32 entries
	localparam int TQ_AW      = 5;

	// Ring occupancy behind the oldest pending trigger that raises WARN
	localparam int WARN_LEVEL = 3328;

	typedef logic [RING_AW-1:0] ring_addr_t;

	// 18-bit ring word, same layout as RDATA
	typedef struct packed {
		logic              multi_ovlp;
		logic              ovlp;
		logic [3:0]        ovlp_cnt;
		logic [SAMP_W-1:0] samp;
	} samp_word_t;

	// 37-bit event header, same layout as L1A_EVT_DATA
	typedef struct packed {
		logic        phase;
		logic [11:0] match_cnt;
		logic [23:0] l1a_cnt;
	} evt_hdr_t;

	// One queued trigger
	typedef struct packed {
		evt_hdr_t   hdr;
		ring_addr_t start_addr;
	} trig_rec_t;

endpackage

// File: src/ringbuf_if.sv
// Trigger queue front, seen by the sequencer and the ring
interface trig_q_if;
	logic                   empty;
	ringbuf_pkg::trig_rec_t head;
	logic                   pop;

	modport queue (
		output empty,
		output head,
		input  pop
	);

	modport sequencer (
		input  empty,
		input  head,
		output pop
	);

	modport monitor (
		input empty,
		input head
	);
endinterface

// Ring read port
interface ring_rd_if;
	logic                    load;
	logic                    rd_en;
	ringbuf_pkg::ring_addr_t rd_addr;
	logic                    avail;

	modport sequencer (
		output load,
		output rd_en,
		output rd_addr,
		input  avail
	);

	modport ring (
		input  load,
		input  rd_en,
		input  rd_addr,
		output avail
	);
endinterface

// File: src/dp_store.sv
module dp_store #(
	parameter type word_t = logic,
	parameter int  AW     = 1
) (
	input  logic          CLK,
	input  logic          we_i,
	input  logic [AW-1:0] waddr_i,
	input  word_t         wdata_i,
	input  logic [AW-1:0] raddr_i,
	output word_t         rdata_o
);

	word_t mem [0:(1 << AW)-1];

	always_ff @(posedge CLK) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// Old data on a same-address collision
	always_ff @(posedge CLK) begin
		rdata_o <= mem[raddr_i];
	end

endmodule

// File: src/sample_ring.sv
module sample_ring (
	input  logic                    CLK,
	input  logic                    RST_RESYNC,
	input  logic                    wren_i,
	input  ringbuf_pkg::samp_word_t wword_i,
	output ringbuf_pkg::ring_addr_t wr_addr_o,
	output ringbuf_pkg::samp_word_t rword_o,
	output logic                    warn_o,
	trig_q_if.monitor               tq,
	ring_rd_if.ring                 rd
);

	ringbuf_pkg::ring_addr_t wr_addr;
	ringbuf_pkg::ring_addr_t wr_next;
	ringbuf_pkg::ring_addr_t head_dist;
	logic                    full;

	assign wr_next = wr_addr + 1'b1;
	assign wr_addr_o = wr_addr;

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_addr <= '0;
		end else if (wren_i) begin
			wr_addr <= wr_next; // Wraps at ring depth
		end
	end

	// Equal addresses mean either nothing or a whole ring to read
	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			full <= 1'b0;
		end else if (rd.load) begin
			full <= wren_i && (wr_next == tq.head.start_addr);
		end else if (wren_i && !rd.rd_en && (wr_next == rd.rd_addr)) begin
			full <= 1'b1;
		end else if (rd.rd_en && !wren_i) begin
			full <= 1'b0;
		end
	end

	assign rd.avail = full || (wr_addr != rd.rd_addr);

	// Distance from the oldest pending start address
	assign head_dist = wr_addr - tq.head.start_addr;
	assign warn_o = !tq.empty && (head_dist > ringbuf_pkg::WARN_LEVEL);

	dp_store #(
		.word_t (ringbuf_pkg::samp_word_t),
		.AW     (ringbuf_pkg::RING_AW)
	) i_ring_mem (
		.CLK     (CLK),
		.we_i    (wren_i),
		.waddr_i (wr_addr),
		.wdata_i (wword_i),
		.raddr_i (rd.rd_addr),
		.rdata_o (rword_o)
	);

	// Sequencer must not read past the writer
	rd_within_written: assert property (
		@(posedge CLK) disable iff (RST_RESYNC)
		rd.rd_en |-> rd.avail
	) else $error("ring read issued with no written word available");

endmodule

// File: src/trig_queue.sv
module trig_queue (
	input  logic                    CLK,
	input  logic                    RST_RESYNC,
	input  logic [37:0]             l1a_smp_i,
	input  logic                    l1a_wrt_en_i,
	input  ringbuf_pkg::ring_addr_t wr_addr_i,
	trig_q_if.queue                 tq
);

	logic [23:0]                    l1a_cnt;
	logic [11:0]                    match_cnt;
	logic                           match;
	logic                           phase;
	ringbuf_pkg::trig_rec_t         rec_in;
	logic [ringbuf_pkg::TQ_AW-1:0]  wptr;
	logic [ringbuf_pkg::TQ_AW-1:0]  rptr;
	logic [ringbuf_pkg::TQ_AW-1:0]  rptr_next;
	logic [ringbuf_pkg::TQ_AW:0]    count;
	logic [ringbuf_pkg::TQ_AW:0]    count_next;
	logic                           full;
	logic                           push;
	logic                           head_ok;

	assign {phase, match, match_cnt, l1a_cnt} = l1a_smp_i;

	assign full = count[ringbuf_pkg::TQ_AW];
	assign push = l1a_wrt_en_i && match && !full; // Dropped when full

	assign rec_in = '{
		hdr: '{phase: phase, match_cnt: match_cnt, l1a_cnt: l1a_cnt},
		start_addr: wr_addr_i
	};

	// Look-ahead read keeps the next head in the output register
	assign rptr_next = tq.pop ? rptr + 1'b1 : rptr;

	always_comb begin
		count_next = count;
		if (push && !tq.pop) begin
			count_next = count + 1'b1;
		end else if (tq.pop && !push) begin
			count_next = count - 1'b1;
		end
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wptr    <= '0;
			rptr    <= '0;
			count   <= '0;
			head_ok <= 1'b0;
		end else begin
			wptr    <= wptr + push;
			rptr    <= rptr_next;
			count   <= count_next;
			head_ok <= (count_next != '0) && !(push && (wptr == rptr_next)); // Entry written now reads next cycle
		end
	end

	assign tq.empty = !head_ok;

	dp_store #(
		.word_t (ringbuf_pkg::trig_rec_t),
		.AW     (ringbuf_pkg::TQ_AW)
	) i_rec_mem (
		.CLK     (CLK),
		.we_i    (push),
		.waddr_i (wptr),
		.wdata_i (rec_in),
		.raddr_i (rptr_next),
		.rdata_o (tq.head)
	);

	pop_needs_head: assert property (
		@(posedge CLK) disable iff (RST_RESYNC)
		tq.pop |-> !tq.empty
	) else $error("trigger queue popped while empty");

endmodule

// File: src/readout_seq.sv
module readout_seq (
	input  logic       CLK,
	input  logic       RST_RESYNC,
	input  logic [6:0] samp_max_i,
	input  logic       evt_buf_afl_i,
	output logic       hdr_load_o,
	trig_q_if.sequencer  tq,
	ring_rd_if.sequencer rd
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_READ
	} seq_state_t;

	seq_state_t              state;
	ringbuf_pkg::ring_addr_t rd_addr;
	logic [6:0]              word_cnt;
	logic                    start_evt;
	logic                    last_word;

	// New event only with room downstream
	assign start_evt = (state == ST_IDLE) && !tq.empty && !evt_buf_afl_i;

	assign tq.pop = start_evt;
	assign rd.load = start_evt;
	assign hdr_load_o = start_evt;

	assign rd.rd_en = (state == ST_READ) && rd.avail && !evt_buf_afl_i;
	assign rd.rd_addr = rd_addr;

	assign last_word = (word_cnt == samp_max_i - 1'b1);

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state    <= ST_IDLE;
			rd_addr  <= '0;
			word_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_evt) begin
						rd_addr <= tq.head.start_addr;
						state   <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					word_cnt <= '0;
					if (samp_max_i == '0) begin
						state <= ST_IDLE; // Header only
					end else begin
						state <= ST_READ;
					end
				end
				ST_READ: begin
					if (rd.rd_en) begin
						rd_addr  <= rd_addr + 1'b1;
						word_cnt <= word_cnt + 1'b1;
						if (last_word) begin
							state <= ST_IDLE;
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: src/readout_out.sv
module readout_out (
	input  logic                    CLK,
	input  logic                    RST_RESYNC,
	input  logic                    hdr_load_i,
	input  ringbuf_pkg::evt_hdr_t   hdr_i,
	input  logic                    rd_en_i,
	input  ringbuf_pkg::samp_word_t rword_i,
	output ringbuf_pkg::evt_hdr_t   L1A_EVT_DATA,
	output logic                    L1A_EVT_PUSH,
	output ringbuf_pkg::samp_word_t RDATA,
	output logic                    DATA_PUSH
);

	logic rd_vld; // Memory word valid on rword_i

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			L1A_EVT_PUSH <= 1'b0;
			rd_vld       <= 1'b0;
			DATA_PUSH    <= 1'b0;
		end else begin
			L1A_EVT_PUSH <= hdr_load_i;
			rd_vld       <= rd_en_i;
			DATA_PUSH    <= rd_vld;
		end
	end

	always_ff @(posedge CLK) begin
		if (hdr_load_i) begin
			L1A_EVT_DATA <= hdr_i;
		end
		if (rd_vld) begin
			RDATA <= rword_i;
		end
	end

endmodule

// File: src/ringbuf_top.sv
module ringbuf_top (
	input  logic                                      CLK,
	input  logic                                      RST_RESYNC,
	input  logic [6:0]                                SAMP_MAX,
	input  logic [ringbuf_pkg::SAMP_W-1:0]            WDATA,
	input  logic                                      WREN,
	input  logic [37:0]                               L1A_SMP_DATA,
	input  logic [6:0]                                OVRLP_SMP_DATA,
	input  logic                                      L1A_WRT_EN,
	input  logic                                      EVT_BUF_AFL,
	output logic [$bits(ringbuf_pkg::evt_hdr_t)-1:0]  L1A_EVT_DATA,
	output logic                                      L1A_EVT_PUSH,
	output logic [$bits(ringbuf_pkg::samp_word_t)-1:0] RDATA,
	output logic                                      DATA_PUSH,
	output logic                                      WARN
);

	trig_q_if  tq_bus ();
	ring_rd_if rd_bus ();

	ringbuf_pkg::samp_word_t wword;
	ringbuf_pkg::samp_word_t rword;
	ringbuf_pkg::ring_addr_t wr_addr;
	logic                    hdr_load;

	// Overlap flags ride with each sample, end-of-event bit is not stored
	assign wword = '{
		multi_ovlp: OVRLP_SMP_DATA[5],
		ovlp:       OVRLP_SMP_DATA[4],
		ovlp_cnt:   OVRLP_SMP_DATA[3:0],
		samp:       WDATA
	};

	trig_queue i_trig_queue (
		.CLK          (CLK),
		.RST_RESYNC   (RST_RESYNC),
		.l1a_smp_i    (L1A_SMP_DATA),
		.l1a_wrt_en_i (L1A_WRT_EN),
		.wr_addr_i    (wr_addr),
		.tq           (tq_bus.queue)
	);

	sample_ring i_sample_ring (
		.CLK        (CLK),
		.RST_RESYNC (RST_RESYNC),
		.wren_i     (WREN),
		.wword_i    (wword),
		.wr_addr_o  (wr_addr),
		.rword_o    (rword),
		.warn_o     (WARN),
		.tq         (tq_bus.monitor),
		.rd         (rd_bus.ring)
	);

	readout_seq i_readout_seq (
		.CLK           (CLK),
		.RST_RESYNC    (RST_RESYNC),
		.samp_max_i    (SAMP_MAX),
		.evt_buf_afl_i (EVT_BUF_AFL),
		.hdr_load_o    (hdr_load),
		.tq            (tq_bus.sequencer),
		.rd            (rd_bus.sequencer)
	);

	readout_out i_readout_out (
		.CLK          (CLK),
		.RST_RESYNC   (RST_RESYNC),
		.hdr_load_i   (hdr_load),
		.hdr_i        (tq_bus.head.hdr),
		.rd_en_i      (rd_bus.rd_en),
		.rword_i      (rword),
		.L1A_EVT_DATA (L1A_EVT_DATA),
		.L1A_EVT_PUSH (L1A_EVT_PUSH),
		.RDATA        (RDATA),
		.DATA_PUSH    (DATA_PUSH)
	);

endmodule

// File: dv/tb_ringbuf.sv
module tb_ringbuf;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_SAMP = 12;

	logic        CLK;
	logic        RST_RESYNC;
	logic [6:0]  SAMP_MAX;
	logic [11:0] WDATA;
	logic        WREN;
	logic [37:0] L1A_SMP_DATA;
	logic [6:0]  OVRLP_SMP_DATA;
	logic        L1A_WRT_EN;
	logic        EVT_BUF_AFL;
	logic [36:0] L1A_EVT_DATA;
	logic        L1A_EVT_PUSH;
	logic [17:0] RDATA;
	logic        DATA_PUSH;
	logic        WARN;

	// Reference model state
	ringbuf_pkg::samp_word_t mem_model [0:4095];
	ringbuf_pkg::evt_hdr_t   hdr_q [$];
	logic [11:0]             start_q [$];
	longint                  start_tot_q [$];
	logic [11:0]             wr_ptr;
	longint                  wr_total; // Words written since reset
	int                      rec_cnt;
	ringbuf_pkg::evt_hdr_t   exp_hdr;
	logic [11:0]             front_start;
	logic [11:0]             cur_start;
	longint                  cur_start_tot;
	int                      data_idx;
	int                      data_left;
	bit                      trig_seen;
	logic [11:0]             rd_ptr_model;
	ringbuf_pkg::samp_word_t exp_rdata;
	logic [11:0]             front_dist;
	logic                    model_warn;

	ringbuf_top i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	assign rd_ptr_model = cur_start + data_idx[11:0]; // Wraps at 4096
	assign exp_rdata = mem_model[rd_ptr_model];
	assign front_dist = wr_ptr - front_start;
	assign model_warn = (rec_cnt != 0) && (front_dist > ringbuf_pkg::WARN_LEVEL);

	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic value_error(input string sig, input logic [63:0] got, input logic [63:0] exp);
		$display("mismatch at %0t ns: %s got %h expected %h", $time, sig, got, exp);
		fail_stop("value check failed");
	endtask

	always @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			hdr_q.delete();
			start_q.delete();
			start_tot_q.delete();
			wr_ptr = '0;
			wr_total = 0;
			rec_cnt = 0;
			data_idx = 0;
			data_left = 0;
			trig_seen = 1'b0;
			cur_start = '0;
			cur_start_tot = 0;
			front_start = '0;
		end else begin
			if (L1A_WRT_EN && L1A_SMP_DATA[36]) begin // Match bit set
				hdr_q.push_back({L1A_SMP_DATA[37], L1A_SMP_DATA[35:0]});
				start_q.push_back(wr_ptr);
				start_tot_q.push_back(wr_total);
				trig_seen = 1'b1;
			end
			if (WREN) begin
				mem_model[wr_ptr] = {OVRLP_SMP_DATA[5:0], WDATA};
				wr_ptr = wr_ptr + 1'b1;
				wr_total = wr_total + 1;
			end
			// Last sample of an event may share the next header's cycle
			if (DATA_PUSH && data_left != 0) begin
				data_idx = data_idx + 1;
				data_left = data_left - 1;
			end
			if (L1A_EVT_PUSH && hdr_q.size() != 0) begin
				void'(hdr_q.pop_front());
				cur_start = start_q.pop_front();
				cur_start_tot = start_tot_q.pop_front();
				data_idx = 0;
				data_left = N_SAMP;
			end
			rec_cnt = hdr_q.size();
			if (rec_cnt != 0) begin
				exp_hdr = hdr_q[0];
				front_start = start_q[0];
			end
		end
	end

	quiet_before_trigger: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		!trig_seen |-> !L1A_EVT_PUSH && !DATA_PUSH && !WARN)
		else fail_stop("output active before any matching trigger");
	hdr_has_trigger: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		L1A_EVT_PUSH |-> rec_cnt != 0)
		else fail_stop("header pushed with no accepted trigger pending");
	hdr_value: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		L1A_EVT_PUSH && rec_cnt != 0 |-> L1A_EVT_DATA == exp_hdr)
		else value_error("L1A_EVT_DATA", $sampled(L1A_EVT_DATA), $sampled(exp_hdr));
	prev_event_done: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		L1A_EVT_PUSH |-> data_left == 0 || (data_left == 1 && DATA_PUSH))
		else fail_stop("header arrived before the previous event had all its samples");
	data_in_event: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		DATA_PUSH |-> data_left != 0)
		else fail_stop("sample pushed with no event sample outstanding");
	data_written: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		DATA_PUSH |-> cur_start_tot + data_idx < wr_total)
		else fail_stop("sample pushed before its ring word was written");
	data_value: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		DATA_PUSH && data_left != 0 |-> RDATA == exp_rdata)
		else value_error("RDATA", $sampled(RDATA), $sampled(exp_rdata));
	afl_stops_output: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		EVT_BUF_AFL [*3] |-> !DATA_PUSH && !L1A_EVT_PUSH)
		else fail_stop("output pushed while the event buffer was almost full");
	warn_only_when_due: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		WARN |-> model_warn)
		else fail_stop("WARN high with no pending trigger beyond the warning level");
	warn_when_due: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		(EVT_BUF_AFL && model_warn) [*3] |-> WARN)
		else fail_stop("WARN low while a pending trigger is beyond the warning level");

	task automatic drive_cycle(input bit wr, input bit trig, input bit match, input bit afl);
		@(posedge CLK);
		#2;
		WREN = wr;
		WDATA = 12'($urandom);
		OVRLP_SMP_DATA = 7'($urandom);
		L1A_WRT_EN = trig;
		L1A_SMP_DATA = {1'($urandom), match, 12'($urandom), 24'($urandom)};
		EVT_BUF_AFL = afl;
	endtask

	task automatic run_traffic(input int cycles, input bit afl_bursts);
		bit wr;
		bit trig;
		bit afl;
		for (int i = 0; i < cycles; i++) begin
			wr = ($urandom % 4) != 0;
			trig = (($urandom % 8) == 0) && (rec_cnt < 20); // Stay below queue depth
			afl = afl_bursts && ((i % 24) >= 18);
			drive_cycle(wr, trig, 1'($urandom), afl);
		end
	endtask

	task automatic write_words(input int n, input bit afl);
		repeat (n) drive_cycle(1'b1, 1'b0, 1'b0, afl);
	endtask

	task automatic drain(input int max_cycles);
		for (int n = 0; n < max_cycles && !(rec_cnt == 0 && data_left == 0); n++) begin
			drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
		end
		if (rec_cnt != 0 || data_left != 0) begin
			fail_stop("timeout waiting for readout to drain");
		end
		drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic wait_warn(input int max_cycles);
		for (int n = 0; n < max_cycles && !WARN; n++) begin
			drive_cycle(1'b0, 1'b0, 1'b0, 1'b1);
		end
		if (!WARN) begin
			fail_stop("timeout waiting for WARN to rise");
		end
	endtask

	initial begin
		void'($urandom(32'h3871_1b5d));
		RST_RESYNC = 1'b1;
		SAMP_MAX = 7'(N_SAMP);
		WDATA = '0;
		WREN = 1'b0;
		L1A_SMP_DATA = '0;
		OVRLP_SMP_DATA = '0;
		L1A_WRT_EN = 1'b0;
		EVT_BUF_AFL = 1'b0;
		repeat (16) @(posedge CLK);
		#2;
		RST_RESYNC = 1'b0;

		repeat (10) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0); // Non-matching triggers only
		run_traffic(400, 1'b0);
		drain(2000);

		// Readout stalls on unwritten words, then resumes
		drive_cycle(1'b1, 1'b1, 1'b1, 1'b0);
		write_words(3, 1'b0);
		repeat (60) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
		assert (data_idx == 4) else value_error("DATA_PUSH count", data_idx, 4);
		drain(2000);

		run_traffic(480, 1'b1);
		drain(2000);

		// Hold AFL with one pending trigger until the ring nears overwrite
		drive_cycle(1'b1, 1'b1, 1'b1, 1'b1);
		write_words(3400, 1'b1);
		wait_warn(8);
		drain(2000);
		repeat (5) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);

		// Event that crosses the ring wrap
		write_words(int'(12'(12'd4091 - wr_ptr)), 1'b0);
		drive_cycle(1'b1, 1'b1, 1'b1, 1'b0);
		drain(2000);
		repeat (5) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);

		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: build.f
src/ringbuf_pkg.sv
src/ringbuf_if.sv
src/dp_store.sv
src/sample_ring.sv
src/trig_queue.sv
src/readout_seq.sv
src/readout_out.sv
src/ringbuf_top.sv
dv/tb_ringbuf.sv
